/* all.f */
+incdir+hdl
hdl/aes_cfg_pkg.sv
hdl/aes_key_pkg.sv
hdl/aes_sub_word.sv
hdl/aes_rot_word.sv
hdl/aes_key_words.sv
hdl/aes_key_ctrl.sv
hdl/aes_key_expand.sv
tb/tb_clk_gen.sv
tb/tb_key_checker.sv
tb/tb_aes_key_expand.sv

/* Makefile */
BIN := obj_dir/Vtb_aes_key_expand

.PHONY: all run clean

all: $(BIN)

$(BIN): all.f $(wildcard hdl/*.sv hdl/*.svh tb/*.sv)
	verilator --binary --timing -f all.f --top-module tb_aes_key_expand -o Vtb_aes_key_expand

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q "^TESTS PASSED$$"

clean:
	rm -rf obj_dir

/* tb/tb_aes_key_expand.sv */
/*
 * Testbench for the AES key expansion engine
 * Runs a table of forward and inverse commands under random back-pressure
 */

`timescale 1ns/1ns

module tb_aes_key_expand;

  typedef struct packed {
    logic [79:0]           name;
    aes_cfg_pkg::ciph_op_e op;
    aes_cfg_pkg::key_len_e len;
    logic                  chain;
    logic [3:0]            steps;
    logic [255:0]          key_be;
    logic [255:0]          final_be;
    logic                  upper_only;
  } row_t;

  logic clk;
  logic rst_n;
  aes_key_pkg::key_cmd_t   cmd;
  logic                    cmd_valid;
  logic                    cmd_ready;
  aes_key_pkg::round_key_t rk;
  logic                    rk_valid;
  logic                    rk_ready;
  logic [79:0]             name;
  logic [3:0]              steps;
  aes_key_pkg::key_state_t final_state;
  aes_key_pkg::key_state_t mask;
  aes_key_pkg::key_state_t prev_final;
  logic                    end_run;
  int                      timeouts;
  int                      errors;
  int                      seed;
  row_t                    rows [4];

  // FIPS-197 byte order into the state layout, byte 0 first
  function automatic aes_key_pkg::key_state_t to_state(logic [255:0] be);
    aes_key_pkg::key_state_t s;
    s = '0;
    for (int i = 0; i < 8; i++) begin
      for (int j = 0; j < 4; j++) s[i][8*j +: 8] = be[255 - 8*(4*i+j) -: 8];
    end
    return s;
  endfunction

  tb_clk_gen i_tb_clk_gen (.clk_o(clk), .rst_no(rst_n));

  aes_key_expand i_aes_key_expand (
    .clk_i       (clk),
    .rst_ni      (rst_n),
    .cmd_i       (cmd),
    .cmd_valid_i (cmd_valid),
    .cmd_ready_o (cmd_ready),
    .rk_o        (rk),
    .rk_valid_o  (rk_valid),
    .rk_ready_i  (rk_ready)
  );

  tb_key_checker i_tb_key_checker (
    .clk_i (clk), .rst_ni (rst_n), .cmd_i (cmd), .cmd_valid_i (cmd_valid),
    .cmd_ready_i (cmd_ready), .rk_i (rk), .rk_valid_i (rk_valid), .rk_ready_i (rk_ready),
    .name_i (name), .steps_i (steps), .final_i (final_state), .mask_i (mask),
    .timeouts_i (timeouts), .end_i (end_run), .errors_o (errors)
  );

  initial begin
    int   waited;
    logic done;
    // Inverse rows start from the previous row's last state
    rows[0] = '{"fwd_aes128", aes_cfg_pkg::CIPH_FWD, aes_cfg_pkg::AES_128, 1'b0, 4'd10,
                {128'h2b7e151628aed2a6abf7158809cf4f3c, 128'h0},
                {128'hd014f9a8c9ee2589e13f0cc8b6630ca6, 128'h0}, 1'b0};
    rows[1] = '{"inv_aes128", aes_cfg_pkg::CIPH_INV, aes_cfg_pkg::AES_128, 1'b1, 4'd10,
                256'h0, {128'h2b7e151628aed2a6abf7158809cf4f3c, 128'h0}, 1'b0};
    rows[2] = '{"fwd_aes256", aes_cfg_pkg::CIPH_FWD, aes_cfg_pkg::AES_256, 1'b0, 4'd13,
                {128'h603deb1015ca71be2b73aef0857d7781, 128'h1f352c073b6108d72d9810a30914dff4},
                {128'h0, 128'hfe4890d1e6188d0b046df344706c631e}, 1'b1};
    rows[3] = '{"inv_aes256", aes_cfg_pkg::CIPH_INV, aes_cfg_pkg::AES_256, 1'b1, 4'd13, 256'h0,
                {128'h603deb1015ca71be2b73aef0857d7781, 128'h1f352c073b6108d72d9810a30914dff4},
                1'b0};
    seed = 32'hd12a_8eac;
    cmd = '0;
    cmd_valid = 1'b0;
    rk_ready = 1'b0;
    name = '0;
    steps = '0;
    final_state = '0;
    mask = '0;
    prev_final = '0;
    end_run = 1'b0;
    timeouts = 0;
    waited = 0;
    while (rst_n !== 1'b1 && waited < 20) begin
      @(posedge clk);
      waited++;
    end
    if (rst_n !== 1'b1) begin
      timeouts++;
      $display("Timeout waiting for reset to be released");
    end
    @(posedge clk);
    #5;
    foreach (rows[r]) begin
      cmd.op      = rows[r].op;
      cmd.key_len = rows[r].len;
      cmd.key     = rows[r].chain ? prev_final : to_state(rows[r].key_be);
      name        = rows[r].name;
      steps       = rows[r].steps;
      final_state = to_state(rows[r].final_be);
      mask        = rows[r].upper_only ? {{4{32'hffff_ffff}}, {4{32'h0}}} : '1;
      cmd_valid   = 1'b1;
      waited = 0;
      done = 1'b0;
      while (!done && waited < 50) begin
        done = cmd_ready;
        @(posedge clk);
        #5;
        waited++;
      end
      cmd_valid = 1'b0;
      if (!done) begin
        timeouts++;
        $display("Timeout waiting for the command to be accepted in test %s", rows[r].name);
      end else begin
        waited = 0;
        done = 1'b0;
        while (!done && waited < 500) begin
          rk_ready = ($random(seed) % 4) != 0;
          if (rk_valid && rk_ready && rk.last) begin
            done = 1'b1;
            prev_final = rk.key;
          end
          @(posedge clk);
          #5;
          waited++;
        end
        rk_ready = 1'b0;
        if (!done) begin
          timeouts++;
          $display("Timeout waiting for the last round key in test %s", rows[r].name);
        end
      end
    end
    repeat (2) @(posedge clk);
    end_run = 1'b1;
    #1;
    if (errors == 0 && timeouts == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

/* tb/tb_key_checker.sv */
/*
 * Round key checker
 * Rebuilds the FIPS-197 key schedule and compares every transferred round key
 */

`timescale 1ns/1ns

module tb_key_checker (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  aes_key_pkg::key_cmd_t   cmd_i,
  input  logic                    cmd_valid_i,
  input  logic                    cmd_ready_i,
  input  aes_key_pkg::round_key_t rk_i,
  input  logic                    rk_valid_i,
  input  logic                    rk_ready_i,
  input  logic [79:0]             name_i,
  input  logic [3:0]              steps_i,
  input  aes_key_pkg::key_state_t final_i,
  input  aes_key_pkg::key_state_t mask_i,
  input  int                      timeouts_i,
  input  logic                    end_i,
  output int                      errors_o
);

  logic [31:0]             w [60];
  aes_key_pkg::key_cmd_t   run_cmd;
  aes_key_pkg::key_state_t run_final;
  aes_key_pkg::key_state_t run_mask;
  aes_key_pkg::round_key_t held_rk;
  aes_key_pkg::round_key_t exp_rk;
  logic [79:0]             run_name;
  logic [3:0]              run_steps;
  logic                    reset_seen = 1'b0;
  logic                    held = 1'b0;
  int                      n = 0;
  int                      total = 0;
  int                      errors = 0;

  assign errors_o = errors;

  //////////////////////////////////////////////////
  // GF(2^8) and S-box model
  //////////////////////////////////////////////////

  function automatic logic [7:0] xtime(logic [7:0] x);
    return {x[6:0], 1'b0} ^ (x[7] ? 8'h1b : 8'h00);
  endfunction

  function automatic logic [7:0] gmul(logic [7:0] a, logic [7:0] b);
    logic [7:0] p;
    logic [7:0] t;
    p = 8'h00;
    t = a;
    for (int i = 0; i < 8; i++) begin
      if (b[i]) p = p ^ t;
      t = xtime(t);
    end
    return p;
  endfunction

  // Inverse as x^254, then the affine map
  function automatic logic [7:0] sbox(logic [7:0] x);
    logic [7:0] r;
    logic [7:0] e;
    r = 8'h01;
    e = x;
    for (int i = 0; i < 8; i++) begin
      if (i != 0) r = gmul(r, e);
      e = gmul(e, e);
    end
    return r ^ {r[6:0], r[7]} ^ {r[5:0], r[7:6]} ^ {r[4:0], r[7:5]} ^
           {r[3:0], r[7:4]} ^ 8'h63;
  endfunction

  function automatic logic [31:0] sub_word(logic [31:0] x);
    return {sbox(x[31:24]), sbox(x[23:16]), sbox(x[15:8]), sbox(x[7:0])};
  endfunction

  //////////////////////////////////////////////////
  // Key expansion, byte 0 of a word in bits 7:0
  //////////////////////////////////////////////////

  task automatic build_schedule(input aes_key_pkg::key_state_t key, input int nk);
    logic [31:0] t;
    logic [7:0]  rc;
    rc = 8'h01;
    for (int i = 0; i < 60; i++) w[i] = (i < nk) ? key[i] : 32'h0;
    for (int i = nk; i < 60; i++) begin
      t = w[i-1];
      if (i % nk == 0) begin
        t = sub_word({t[7:0], t[31:8]});
        t[7:0] = t[7:0] ^ rc;
        rc = xtime(rc);
      end else if (nk == 8 && i % 8 == 4) begin
        t = sub_word(t);
      end
      w[i] = w[i-nk] ^ t;
    end
  endtask

  // Expected n-th transfer of the current run
  function automatic aes_key_pkg::round_key_t model_key(int idx);
    aes_key_pkg::round_key_t e;
    int nk;
    int r;
    int base;
    logic fwd;
    fwd  = (run_cmd.op == aes_cfg_pkg::CIPH_FWD);
    nk   = (run_cmd.key_len == aes_cfg_pkg::AES_256) ? 8 : 4;
    r    = fwd ? idx : int'(run_steps) - idx + 1;
    base = fwd ? 4 * r : 4 * (r - 1);
    e = '0;
    for (int i = 0; i < nk; i++) e.key[i] = w[base+i];
    e.round = 4'(r);
    e.last  = (idx == int'(run_steps));
    return e;
  endfunction

  //////////////////////////////////////////////////
  // Monitor, sampled mid cycle
  //////////////////////////////////////////////////

  always @(negedge clk_i) begin
    if (rst_ni && !reset_seen) begin
      reset_seen = 1'b1;
      if (!cmd_ready_i || rk_valid_i) begin
        errors++;
        $display("After reset cmd_ready_o is not high or rk_valid_o is not low");
      end
    end
    // Command taken at the next rising edge
    if (rst_ni && cmd_valid_i && cmd_ready_i) begin
      run_cmd   = cmd_i;
      run_name  = name_i;
      run_steps = steps_i;
      run_final = final_i;
      run_mask  = mask_i;
      n = 0;
      build_schedule((cmd_i.op == aes_cfg_pkg::CIPH_FWD) ? cmd_i.key : final_i,
                     (cmd_i.key_len == aes_cfg_pkg::AES_256) ? 8 : 4);
    end
    if (held && rk_valid_i && rk_i != held_rk) begin
      errors++;
      $display("Round key changed while waiting for ready in test %s", run_name);
    end
    held    = rk_valid_i && !rk_ready_i;
    held_rk = rk_i;
    if (rk_valid_i && rk_ready_i) begin
      n++;
      total++;
      if (n > int'(run_steps)) begin
        errors++;
        $display("Extra round key %0d beyond the expected count in test %s", n, run_name);
      end else begin
        exp_rk = model_key(n);
        if (rk_i != exp_rk) begin
          errors++;
          $display("MISMATCH %s key %0d expected %h actual %h", run_name, n, exp_rk, rk_i);
        end
        if (exp_rk.last && ((rk_i.key & run_mask) != (run_final & run_mask))) begin
          errors++;
          $display("MISMATCH %s final state expected %h actual %h", run_name,
                   run_final & run_mask, rk_i.key & run_mask);
        end
      end
    end
  end

  always @(posedge end_i) begin
    $display("Round keys checked: %0d, errors: %0d, timeouts: %0d", total, errors, timeouts_i);
  end

endmodule

/* tb/tb_clk_gen.sv */
/*
 * Testbench clock and reset
 * 40 ns clock, reset held low for 10 cycles
 */

`timescale 1ns/1ns

module tb_clk_gen (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o = 1'b0;
    forever #20 clk_o = ~clk_o;
  end

  // Release shortly after the tenth rising edge
  initial begin
    rst_no = 1'b0;
    repeat (10) @(posedge clk_o);
    #5;
    rst_no = 1'b1;
  end

endmodule

/* hdl/aes_key_expand.sv */
/*
 * AES key expansion engine, AES-128 and AES-256
 * Walks the key schedule forward or backward one state per round key
 */

`timescale 1ns/1ns

`include "aes_key_macros.svh"

module aes_key_expand (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  aes_key_pkg::key_cmd_t   cmd_i,
  input  logic                    cmd_valid_i,
  output logic                    cmd_ready_o,
  output aes_key_pkg::round_key_t rk_o,
  output logic                    rk_valid_o,
  input  logic                    rk_ready_i
);

  aes_key_pkg::key_ctrl_t  ctrl;
  aes_key_pkg::key_state_t key_state;
  logic [`AES_WORD_W-1:0]  rot_word;
  logic [`AES_WORD_W-1:0]  sub_word;

  // FSM, rounds and Rcon
  aes_key_ctrl i_aes_key_ctrl (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .cmd_i       (cmd_i),
    .cmd_valid_i (cmd_valid_i),
    .cmd_ready_o (cmd_ready_o),
    .ctrl_o      (ctrl),
    .state_i     (key_state),
    .rk_o        (rk_o),
    .rk_valid_o  (rk_valid_o),
    .rk_ready_i  (rk_ready_i)
  );

  // Irregular path
  aes_rot_word i_aes_rot_word (
    .state_i (key_state),
    .ctrl_i  (ctrl),
    .word_o  (rot_word)
  );

  aes_sub_word i_aes_sub_word (
    .word_i (rot_word),
    .word_o (sub_word)
  );

  // State register and XOR network
  aes_key_words i_aes_key_words (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .cmd_i   (cmd_i),
    .ctrl_i  (ctrl),
    .sub_i   (sub_word),
    .state_o (key_state)
  );

endmodule

/* hdl/aes_key_ctrl.sv */
/*
 * AES key schedule controller
 * FSM with command and round key handshakes, round counter and Rcon
 */

`timescale 1ns/1ns

`include "aes_key_macros.svh"

module aes_key_ctrl (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  aes_key_pkg::key_cmd_t   cmd_i,
  input  logic                    cmd_valid_i,
  output logic                    cmd_ready_o,
  output aes_key_pkg::key_ctrl_t  ctrl_o,
  input  aes_key_pkg::key_state_t state_i,
  output aes_key_pkg::round_key_t rk_o,
  output logic                    rk_valid_o,
  input  logic                    rk_ready_i
);

  localparam logic [3:0] STEPS_128 = 4'(`AES128_STEPS);
  localparam logic [3:0] STEPS_256 = 4'(`AES256_STEPS);

  aes_cfg_pkg::ctrl_state_e state_q, state_d;
  aes_cfg_pkg::ciph_op_e    op_q;
  aes_cfg_pkg::key_len_e    len_q;
  logic [3:0]               rnd_q;
  logic [7:0]               rcon_q;

  logic       accept;
  logic       fwd;
  logic [3:0] steps;
  logic       last;
  logic       skip;
  logic [7:0] rcon_seed;

  assign accept = cmd_valid_i & (state_q == aes_cfg_pkg::IDLE);
  assign fwd    = (op_q == aes_cfg_pkg::CIPH_FWD);
  assign steps  = (len_q == aes_cfg_pkg::AES_256) ? STEPS_256 : STEPS_128;

  // Forward counts up to steps, inverse counts down to 1
  assign last = fwd ? (rnd_q == steps) : (rnd_q == 4'd1);

  // AES-256 even rounds use plain SubWord
  assign skip = (len_q == aes_cfg_pkg::AES_256) & ~rnd_q[0];

  always_comb begin
    if (fwd) begin
      rcon_seed = `AES_RCON_FWD;
    end else if (len_q == aes_cfg_pkg::AES_256) begin
      rcon_seed = `AES_RCON_INV256;
    end else begin
      rcon_seed = `AES_RCON_INV128;
    end
  end

  //////////////////////////////////////////////////
  // FSM
  //////////////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      aes_cfg_pkg::IDLE: if (cmd_valid_i) state_d = aes_cfg_pkg::LOAD;
      aes_cfg_pkg::LOAD: state_d = aes_cfg_pkg::STEP;
      aes_cfg_pkg::STEP: state_d = aes_cfg_pkg::HOLD;
      // Wait for the consumer, then next step or done
      aes_cfg_pkg::HOLD: begin
        if (rk_ready_i) state_d = last ? aes_cfg_pkg::IDLE : aes_cfg_pkg::STEP;
      end
      default: state_d = aes_cfg_pkg::IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= aes_cfg_pkg::IDLE;
      op_q    <= aes_cfg_pkg::CIPH_FWD;
      len_q   <= aes_cfg_pkg::AES_128;
      rnd_q   <= '0;
      rcon_q  <= '0;
    end else begin
      state_q <= state_d;
      // Command fields kept for the whole run
      if (accept) begin
        op_q  <= cmd_i.op;
        len_q <= cmd_i.key_len;
      end
      // Seeds
      if (state_q == aes_cfg_pkg::LOAD) begin
        rnd_q  <= fwd ? 4'd1 : steps;
        rcon_q <= rcon_seed;
      end
      // Rcon moves on only after a step that consumed it
      if (state_q == aes_cfg_pkg::STEP && !skip) begin
        rcon_q <= fwd ? aes_key_pkg::rcon_mul2(rcon_q) : aes_key_pkg::rcon_div2(rcon_q);
      end
      // Round advances once the key is taken
      if (state_q == aes_cfg_pkg::HOLD && rk_ready_i && !last) begin
        rnd_q <= fwd ? rnd_q + 4'd1 : rnd_q - 4'd1;
      end
    end
  end

  //////////////////////////////////////////////////
  // Outputs
  //////////////////////////////////////////////////

  assign cmd_ready_o = (state_q == aes_cfg_pkg::IDLE);
  assign rk_valid_o  = (state_q == aes_cfg_pkg::HOLD);

  always_comb begin
    ctrl_o.op       = op_q;
    ctrl_o.key_len  = len_q;
    ctrl_o.rnd      = rnd_q;
    ctrl_o.load     = accept;
    ctrl_o.step     = (state_q == aes_cfg_pkg::STEP);
    ctrl_o.use_rot  = ~skip;
    ctrl_o.use_rcon = ~skip;
    ctrl_o.rcon     = rcon_q;
    // Stable through HOLD since nothing updates there
    rk_o.key        = state_i;
    rk_o.round      = rnd_q;
    rk_o.last       = last;
  end

endmodule

/* hdl/aes_key_words.sv */
/*
 * AES key word datapath
 * Holds the key state, adds Rcon to the irregular word and builds
 * the next state for either direction and key length
 */

`timescale 1ns/1ns

`include "aes_key_macros.svh"

module aes_key_words (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  aes_key_pkg::key_cmd_t   cmd_i,
  input  aes_key_pkg::key_ctrl_t  ctrl_i,
  input  logic [`AES_WORD_W-1:0]  sub_i,
  output aes_key_pkg::key_state_t state_o
);

  aes_key_pkg::key_state_t state_q;
  aes_key_pkg::key_state_t regular;
  logic [`AES_WORD_W-1:0]  irregular;

  //////////////////////////////////////////////////
  // Irregular word
  //////////////////////////////////////////////////

  // Rcon only touches byte 0
  assign irregular = ctrl_i.use_rcon ?
                     {sub_i[`AES_WORD_W-1:8], sub_i[7:0] ^ ctrl_i.rcon} : sub_i;

  //////////////////////////////////////////////////
  // Regular words
  //////////////////////////////////////////////////

  always_comb begin
    regular = state_q;
    unique case (ctrl_i.key_len)
      aes_cfg_pkg::AES_128: begin
        // Upper half unused, kept clear
        regular[7:4] = '0;
        regular[0]   = irregular ^ state_q[0];
        if (ctrl_i.op == aes_cfg_pkg::CIPH_FWD) begin
          // Running XOR chain
          for (int i = 1; i < 4; i++) begin
            regular[i] = regular[i-1] ^ state_q[i];
          end
        end else begin
          // Neighbour pairs undo the chain
          for (int i = 1; i < 4; i++) begin
            regular[i] = state_q[i-1] ^ state_q[i];
          end
        end
      end

      aes_cfg_pkg::AES_256: begin
        if (ctrl_i.op == aes_cfg_pkg::CIPH_FWD) begin
          // Old upper half moves down
          regular[3:0] = state_q[7:4];
          // New upper half
          regular[4]   = irregular ^ state_q[0];
          for (int i = 1; i < 4; i++) begin
            regular[i+4] = regular[i+3] ^ state_q[i];
          end
        end else begin
          // Old lower half moves up
          regular[7:4] = state_q[3:0];
          // New lower half
          regular[0]   = irregular ^ state_q[4];
          for (int i = 0; i < 3; i++) begin
            regular[i+1] = state_q[4+i] ^ state_q[5+i];
          end
        end
      end

      default: begin
        regular = state_q;
      end
    endcase
  end

  //////////////////////////////////////////////////
  // State register
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= '0;
    end else if (ctrl_i.load) begin
      // Key taken on command acceptance
      state_q <= cmd_i.key;
    end else if (ctrl_i.step) begin
      state_q <= regular;
    end
  end

  assign state_o = state_q;

endmodule

/* hdl/aes_rot_word.sv */
/*
 * AES RotWord stage
 * Picks the source word for the irregular path and rotates it by one byte
 */

`timescale 1ns/1ns

`include "aes_key_macros.svh"

module aes_rot_word (
  input  aes_key_pkg::key_state_t  state_i,
  input  aes_key_pkg::key_ctrl_t   ctrl_i,
  output logic [`AES_WORD_W-1:0]   word_o
);

  logic [`AES_WORD_W-1:0] rot_in;
  logic [`AES_WORD_W-1:0] rot_out;

  // Source word per length and direction
  always_comb begin
    unique case (ctrl_i.key_len)
      aes_cfg_pkg::AES_128: begin
        // Inverse needs the previous last word, rebuilt from two words
        rot_in = (ctrl_i.op == aes_cfg_pkg::CIPH_FWD) ? state_i[3] :
                                                        state_i[3] ^ state_i[2];
      end
      aes_cfg_pkg::AES_256: begin
        rot_in = (ctrl_i.op == aes_cfg_pkg::CIPH_FWD) ? state_i[7] : state_i[3];
      end
      default: begin
        rot_in = state_i[3];
      end
    endcase
  end

  // Byte 0 moves to the top, the rest shifts down
  assign rot_out = {rot_in[7:0], rot_in[`AES_WORD_W-1:8]};

  // Even AES-256 steps feed SubWord without rotation
  assign word_o = ctrl_i.use_rot ? rot_out : rot_in;

endmodule

/* hdl/aes_sub_word.sv */
/*
 * AES SubWord
 * Substitutes the four bytes of one word through the forward S-box
 */

`timescale 1ns/1ns

`include "aes_key_macros.svh"

module aes_sub_word (
  input  logic [`AES_WORD_W-1:0] word_i,
  output logic [`AES_WORD_W-1:0] word_o
);

  // Forward S-box, indexed by input byte
  localparam logic [7:0] SBOX [256] = '{
    8'h63, 8'h7c, 8'h77, 8'h7b, 8'hf2, 8'h6b, 8'h6f, 8'hc5,
    8'h30, 8'h01, 8'h67, 8'h2b, 8'hfe, 8'hd7, 8'hab, 8'h76,
    8'hca, 8'h82, 8'hc9, 8'h7d, 8'hfa, 8'h59, 8'h47, 8'hf0,
    8'had, 8'hd4, 8'ha2, 8'haf, 8'h9c, 8'ha4, 8'h72, 8'hc0,
    8'hb7, 8'hfd, 8'h93, 8'h26, 8'h36, 8'h3f, 8'hf7, 8'hcc,
    8'h34, 8'ha5, 8'he5, 8'hf1, 8'h71, 8'hd8, 8'h31, 8'h15,
    8'h04, 8'hc7, 8'h23, 8'hc3, 8'h18, 8'h96, 8'h05, 8'h9a,
    8'h07, 8'h12, 8'h80, 8'he2, 8'heb, 8'h27, 8'hb2, 8'h75,
    8'h09, 8'h83, 8'h2c, 8'h1a, 8'h1b, 8'h6e, 8'h5a, 8'ha0,
    8'h52, 8'h3b, 8'hd6, 8'hb3, 8'h29, 8'he3, 8'h2f, 8'h84,
    8'h53, 8'hd1, 8'h00, 8'hed, 8'h20, 8'hfc, 8'hb1, 8'h5b,
    8'h6a, 8'hcb, 8'hbe, 8'h39, 8'h4a, 8'h4c, 8'h58, 8'hcf,
    8'hd0, 8'hef, 8'haa, 8'hfb, 8'h43, 8'h4d, 8'h33, 8'h85,
    8'h45, 8'hf9, 8'h02, 8'h7f, 8'h50, 8'h3c, 8'h9f, 8'ha8,
    8'h51, 8'ha3, 8'h40, 8'h8f, 8'h92, 8'h9d, 8'h38, 8'hf5,
    8'hbc, 8'hb6, 8'hda, 8'h21, 8'h10, 8'hff, 8'hf3, 8'hd2,
    8'hcd, 8'h0c, 8'h13, 8'hec, 8'h5f, 8'h97, 8'h44, 8'h17,
    8'hc4, 8'ha7, 8'h7e, 8'h3d, 8'h64, 8'h5d, 8'h19, 8'h73,
    8'h60, 8'h81, 8'h4f, 8'hdc, 8'h22, 8'h2a, 8'h90, 8'h88,
    8'h46, 8'hee, 8'hb8, 8'h14, 8'hde, 8'h5e, 8'h0b, 8'hdb,
    8'he0, 8'h32, 8'h3a, 8'h0a, 8'h49, 8'h06, 8'h24, 8'h5c,
    8'hc2, 8'hd3, 8'hac, 8'h62, 8'h91, 8'h95, 8'he4, 8'h79,
    8'he7, 8'hc8, 8'h37, 8'h6d, 8'h8d, 8'hd5, 8'h4e, 8'ha9,
    8'h6c, 8'h56, 8'hf4, 8'hea, 8'h65, 8'h7a, 8'hae, 8'h08,
    8'hba, 8'h78, 8'h25, 8'h2e, 8'h1c, 8'ha6, 8'hb4, 8'hc6,
    8'he8, 8'hdd, 8'h74, 8'h1f, 8'h4b, 8'hbd, 8'h8b, 8'h8a,
    8'h70, 8'h3e, 8'hb5, 8'h66, 8'h48, 8'h03, 8'hf6, 8'h0e,
    8'h61, 8'h35, 8'h57, 8'hb9, 8'h86, 8'hc1, 8'h1d, 8'h9e,
    8'he1, 8'hf8, 8'h98, 8'h11, 8'h69, 8'hd9, 8'h8e, 8'h94,
    8'h9b, 8'h1e, 8'h87, 8'he9, 8'hce, 8'h55, 8'h28, 8'hdf,
    8'h8c, 8'ha1, 8'h89, 8'h0d, 8'hbf, 8'he6, 8'h42, 8'h68,
    8'h41, 8'h99, 8'h2d, 8'h0f, 8'hb0, 8'h54, 8'hbb, 8'h16
  };

  // One lookup per byte lane
  for (genvar i = 0; i < `AES_WORD_W / 8; i++) begin : gen_sbox
    assign word_o[8*i +: 8] = SBOX[word_i[8*i +: 8]];
  end

endmodule

/* hdl/aes_key_pkg.sv */
/*
 * AES key schedule data types
 * Command, round key and control word structs plus Rcon arithmetic
 */

`include "aes_key_macros.svh"

package aes_key_pkg;

  // Full key state, word 0 holds the first key word
  // Byte 0 of every word sits in bits 7:0
  typedef logic [`AES_KEY_WORDS-1:0][`AES_WORD_W-1:0] key_state_t;

  // Command into the engine
  typedef struct packed {
    aes_cfg_pkg::ciph_op_e op;
    aes_cfg_pkg::key_len_e key_len;
    key_state_t            key;
  } key_cmd_t;

  // One produced key state
  typedef struct packed {
    key_state_t key;
    logic [3:0] round;
    logic       last;
  } round_key_t;

  // Controller to datapath
  typedef struct packed {
    aes_cfg_pkg::ciph_op_e op;
    aes_cfg_pkg::key_len_e key_len;
    logic [3:0]            rnd;
    logic                  load;
    logic                  step;
    logic                  use_rot;
    logic                  use_rcon;
    logic [7:0]            rcon;
  } key_ctrl_t;

  // Times x in GF(2^8), AES polynomial
  function automatic logic [7:0] rcon_mul2(logic [7:0] x);
    return {x[6:0], 1'b0} ^ (x[7] ? 8'h1b : 8'h00);
  endfunction

  // Inverse of rcon_mul2
  function automatic logic [7:0] rcon_div2(logic [7:0] x);
    return {1'b0, x[7:1]} ^ (x[0] ? 8'h8d : 8'h00);
  endfunction

endpackage

/* hdl/aes_cfg_pkg.sv */
/*
 * AES key schedule configuration types
 * Cipher direction, key length and controller state encodings
 */

package aes_cfg_pkg;

  // Direction of the key walk
  typedef enum logic {
    CIPH_FWD = 1'b0,
    CIPH_INV = 1'b1
  } ciph_op_e;

  // Supported key lengths
  typedef enum logic {
    AES_128 = 1'b0,
    AES_256 = 1'b1
  } key_len_e;

  // Controller states
  typedef enum logic [1:0] {
    IDLE = 2'b00,
    LOAD = 2'b01,
    STEP = 2'b10,
    HOLD = 2'b11
  } ctrl_state_e;

endpackage

/* hdl/aes_key_macros.svh */
/*
 * AES key schedule constants
 * Word and state sizes, step counts per key length and Rcon seeds
 */

`ifndef AES_KEY_MACROS_SVH
`define AES_KEY_MACROS_SVH

// One key word and the number of words in the state
`define AES_WORD_W      32
`define AES_KEY_WORDS   8

// Update steps per run
`define AES128_STEPS    10
`define AES256_STEPS    13

// Rcon start values
`define AES_RCON_FWD    8'h01
`define AES_RCON_INV128 8'h36
`define AES_RCON_INV256 8'h40

`endif
